/* files.f */
+incdir+hw
hw/rc4_pkg.sv
hw/rc4_apb_regs.sv
hw/rc4_keystream.sv
hw/rc4_word_xor.sv
hw/rc4_decrypt_top.sv
bench/tb_clock_gen.sv
bench/tb_rc4_decrypt.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the RC4 decrypt testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal --top-module tb_rc4_decrypt -f files.f -o tb_sim \
	&& ./obj_dir/tb_sim 2>&1 | tee sim.log \
	|| echo "Build or simulation stopped with an error"

grep -q "Simulation completed successfully" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* bench/tb_rc4_decrypt.sv */
`timescale 1ns/1ps
`include "rc4_cfg.svh"

module tb_rc4_decrypt;
	import rc4_pkg::*;

	localparam int RESET_CYCLES = 5;

	// Cycle budget
	// One key schedule is a 256-cycle fill plus three cycles per swap plus polling slack
	localparam int SCHED_CYCLES = 1050;
	localparam int SCHED_RUNS   = 4;
	// One word is four bytes at about four cycles each plus two APB transfers
	localparam int WORD_CYCLES  = 40;
	localparam int WORD_RUNS    = 20;
	// Four times the estimate
	localparam int TIMEOUT_CYCLES = 4 * (SCHED_RUNS * SCHED_CYCLES + WORD_RUNS * WORD_CYCLES);

	// STATUS bits
	localparam rc4_word_t STAT_KEY_READY   = 32'h1;
	localparam rc4_word_t STAT_PLAIN_VALID = 32'h2;
	localparam rc4_word_t STAT_CIPHER_BUSY = 32'h4;

	// Unmapped offsets inside the 4-bit window
	localparam logic [`RC4_ADDR_W-1:0] ADDR_HOLE_RD = 4'h2;
	localparam logic [`RC4_ADDR_W-1:0] ADDR_HOLE_WR = 4'h6;

	logic                   tb_clk;
	logic                   rst_n;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [`RC4_ADDR_W-1:0] paddr;
	logic [`RC4_DATA_W-1:0] pwdata;
	logic [`RC4_DATA_W-1:0] prdata;
	logic                   pready;
	logic                   pslverr;

	integer seed = 16178;
	integer cycle_count = 0;

	// Access cycles with pready low in the last transfer
	integer wait_cycles = 0;

	// Reference cipher state
	integer model_s [0:`RC4_TABLE_SIZE-1];
	integer model_i;
	integer model_j;

	tb_clock_gen #(.PERIOD_NS(40)) i_clk_gen (
		.tb_clk (tb_clk)
	);

	rc4_decrypt_top i_dut (
		.tb_clk  (tb_clk),
		.rst_n   (rst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	// Run limit
	always @(posedge tb_clk)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Checking and bus access
	//////////////////////////////////////////////////////////////////////

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
		begin
			$display("error: time %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "check mismatch");
		end
	endtask

	// One APB transfer driven on falling edges
	// Responses are sampled 1 ns after the falling edge
	task automatic apb_transfer(input logic write, input logic [`RC4_ADDR_W-1:0] addr,
			input rc4_word_t wdata, output rc4_word_t rdata, output logic slverr);
		@(negedge tb_clk);
		// Setup phase
		psel    = 1'b1;
		penable = 1'b0;
		pwrite  = write;
		paddr   = addr;
		pwdata  = wdata;
		@(negedge tb_clk);
		// Access phase held until pready
		penable = 1'b1;
		wait_cycles = 0;
		#1;
		while (!pready)
		begin
			@(negedge tb_clk);
			#1;
			wait_cycles = wait_cycles + 1;
		end
		rdata  = prdata;
		slverr = pslverr;
		// Transfer completes on this edge
		@(posedge tb_clk);
		@(negedge tb_clk);
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	task automatic apb_write(input logic [`RC4_ADDR_W-1:0] addr, input rc4_word_t wdata,
			output logic slverr);
		rc4_word_t unused_rd;
		apb_transfer(1'b1, addr, wdata, unused_rd, slverr);
	endtask

	task automatic apb_read(input logic [`RC4_ADDR_W-1:0] addr, output rc4_word_t rdata,
			output logic slverr);
		apb_transfer(1'b0, addr, '0, rdata, slverr);
	endtask

	// Polls STATUS until any masked bit is set
	task automatic wait_status_bit(input rc4_word_t mask);
		rc4_word_t rd;
		logic      err;
		rd = '0;
		while ((rd & mask) == '0)
		begin
			apb_read(`RC4_REG_STATUS, rd, err);
			check_value(err, 1'b0, "pslverr on STATUS poll");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// RC4 reference model
	//////////////////////////////////////////////////////////////////////

	// Identity fill then key scheduling swaps
	// Key byte n sits in bits 8n+7:8n
	task automatic model_schedule(input rc4_word_t key_word);
		integer n;
		integer j;
		integer tmp;
		integer key_byte;
		for (n = 0; n < `RC4_TABLE_SIZE; n++)
			model_s[n] = n;
		j = 0;
		for (n = 0; n < `RC4_TABLE_SIZE; n++)
		begin
			key_byte = 0;
			key_byte[7:0] = key_word[8 * (n % `RC4_KEY_BYTES) +: 8];
			j = (j + model_s[n] + key_byte) % `RC4_TABLE_SIZE;
			tmp = model_s[n];
			model_s[n] = model_s[j];
			model_s[j] = tmp;
		end
		model_i = 0;
		model_j = 0;
	endtask

	// Next four keystream bytes with the first byte in the low lane
	task automatic model_next_word(output rc4_word_t ks);
		integer lane;
		integer tmp;
		integer t;
		ks = '0;
		for (lane = 0; lane < 4; lane++)
		begin
			model_i = (model_i + 1) % `RC4_TABLE_SIZE;
			model_j = (model_j + model_s[model_i]) % `RC4_TABLE_SIZE;
			tmp = model_s[model_i];
			model_s[model_i] = model_s[model_j];
			model_s[model_j] = tmp;
			t = (model_s[model_i] + model_s[model_j]) % `RC4_TABLE_SIZE;
			ks[lane * 8 +: 8] = model_s[t][7:0];
		end
	endtask

	// Random plaintext is encrypted here and decrypted by the DUT
	task automatic decrypt_one_word();
		rc4_word_t plain;
		rc4_word_t ks;
		rc4_word_t rd;
		logic      err;
		plain = $random(seed);
		model_next_word(ks);
		apb_write(`RC4_REG_DATA, plain ^ ks, err);
		check_value(err, 1'b0, "pslverr on DATA write");
		apb_read(`RC4_REG_DATA, rd, err);
		check_value(err, 1'b0, "pslverr on DATA read");
		check_value(rd, plain, "decrypted word");
	endtask

	//////////////////////////////////////////////////////////////////////
	// Tests
	//////////////////////////////////////////////////////////////////////

	task automatic test_reset_state();
		rc4_word_t rd;
		logic      err;
		// Bus idle after reset
		check_value(pready, 1'b0, "pready while idle");
		apb_read(`RC4_REG_STATUS, rd, err);
		check_value(err, 1'b0, "pslverr on STATUS read");
		check_value(wait_cycles, 0, "wait states on STATUS read");
		check_value(rd, 32'h0, "STATUS after reset");
		apb_write(`RC4_REG_KEY, 32'hA5C3_0F96, err);
		check_value(err, 1'b0, "pslverr on KEY write");
		check_value(wait_cycles, 0, "wait states on KEY write");
		apb_read(`RC4_REG_KEY, rd, err);
		check_value(err, 1'b0, "pslverr on KEY read");
		check_value(wait_cycles, 0, "wait states on KEY read");
		check_value(rd, 32'hA5C3_0F96, "KEY readback");
	endtask

	task automatic test_error_responses();
		rc4_word_t rd;
		logic      err;
		apb_read(ADDR_HOLE_RD, rd, err);
		check_value(err, 1'b1, "pslverr on unmapped read");
		check_value(wait_cycles, 0, "wait states on unmapped read");
		apb_write(ADDR_HOLE_WR, 32'h1111_2222, err);
		check_value(err, 1'b1, "pslverr on unmapped write");
		check_value(wait_cycles, 0, "wait states on unmapped write");
		// No START yet
		// Two accepted words would leave the holding register full
		apb_write(`RC4_REG_DATA, 32'hDEAD_BEEF, err);
		check_value(err, 1'b1, "pslverr on DATA write before START");
		check_value(wait_cycles, 0, "wait states on DATA write before START");
		apb_write(`RC4_REG_DATA, 32'hFEED_C0DE, err);
		check_value(err, 1'b1, "pslverr on second DATA write before START");
		check_value(wait_cycles, 0, "wait states on second DATA write before START");
		apb_read(`RC4_REG_STATUS, rd, err);
		check_value(err, 1'b0, "pslverr on STATUS read");
		check_value(rd, 32'h0, "STATUS after rejected DATA writes");
	endtask

	task automatic test_drj_decrypt();
		rc4_word_t key_drj;
		rc4_word_t rd;
		logic      err;
		// Key bytes D, R, ., J with D in byte 0
		key_drj = {8'h4A, 8'h2E, 8'h52, 8'h44};
		apb_write(`RC4_REG_KEY, key_drj, err);
		check_value(err, 1'b0, "pslverr on KEY write");
		apb_write(`RC4_REG_CTRL, 32'h1, err);
		check_value(err, 1'b0, "pslverr on CTRL write");
		check_value(wait_cycles, 0, "wait states on CTRL write");
		wait_status_bit(STAT_KEY_READY);
		apb_read(`RC4_REG_STATUS, rd, err);
		check_value(rd, STAT_KEY_READY, "STATUS after key scheduling");
		model_schedule(key_drj);
		repeat (8)
			decrypt_one_word();
	endtask

	// Two words go in flight and a read then frees room for a third
	// A third write before any read would stall for good since the XOR stage keeps its word
	task automatic test_back_pressure();
		rc4_word_t plain [0:2];
		rc4_word_t cipher [0:2];
		rc4_word_t ks;
		rc4_word_t rd;
		logic      err;
		integer    n;
		for (n = 0; n < 3; n++)
		begin
			plain[n] = $random(seed);
			model_next_word(ks);
			cipher[n] = plain[n] ^ ks;
		end
		apb_write(`RC4_REG_DATA, cipher[0], err);
		check_value(err, 1'b0, "pslverr on first DATA write");
		apb_write(`RC4_REG_DATA, cipher[1], err);
		check_value(err, 1'b0, "pslverr on second DATA write");
		wait_status_bit(STAT_PLAIN_VALID);
		// Word 1 still sits in the holding register
		apb_read(`RC4_REG_STATUS, rd, err);
		check_value(rd, STAT_KEY_READY | STAT_PLAIN_VALID | STAT_CIPHER_BUSY,
			"STATUS with two words in flight");
		apb_read(`RC4_REG_DATA, rd, err);
		check_value(rd, plain[0], "first queued word");
		apb_write(`RC4_REG_DATA, cipher[2], err);
		check_value(err, 1'b0, "pslverr on third DATA write");
		// Read stalls until the XOR stage finishes
		apb_read(`RC4_REG_DATA, rd, err);
		check_value(rd, plain[1], "second queued word");
		apb_read(`RC4_REG_DATA, rd, err);
		check_value(rd, plain[2], "third queued word");
	endtask

	task automatic test_restart();
		rc4_word_t new_key;
		rc4_word_t rd;
		logic      err;
		new_key = $random(seed);
		// One word in the XOR stage and one in the holding register for the restart to drop
		apb_write(`RC4_REG_DATA, 32'h0BAD_F00D, err);
		check_value(err, 1'b0, "pslverr on DATA write before restart");
		apb_write(`RC4_REG_DATA, 32'h600D_CAFE, err);
		check_value(err, 1'b0, "pslverr on second DATA write before restart");
		apb_write(`RC4_REG_KEY, new_key, err);
		check_value(err, 1'b0, "pslverr on new KEY write");
		apb_read(`RC4_REG_KEY, rd, err);
		check_value(rd, new_key, "new KEY readback");
		apb_write(`RC4_REG_CTRL, 32'h1, err);
		check_value(err, 1'b0, "pslverr on restart");
		wait_status_bit(STAT_KEY_READY);
		apb_read(`RC4_REG_STATUS, rd, err);
		check_value(rd, STAT_KEY_READY, "STATUS after restart");
		model_schedule(new_key);
		decrypt_one_word();
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		rst_n   = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (RESET_CYCLES)
			@(negedge tb_clk);
		rst_n = 1'b1;

		test_reset_state();
		test_error_responses();
		test_drj_decrypt();
		test_back_pressure();
		test_restart();

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

/* bench/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
	// Full clock period in ns
	parameter int PERIOD_NS = 40
) (
	output logic tb_clk
);

	// Free-running clock, low at time zero
	initial
	begin
		tb_clk = 1'b0;
		forever
			#(PERIOD_NS / 2) tb_clk = ~tb_clk;
	end

endmodule

/* hw/rc4_decrypt_top.sv */
`timescale 1ns/1ps
`include "rc4_cfg.svh"

module rc4_decrypt_top (
	input  logic                   tb_clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`RC4_ADDR_W-1:0] paddr,
	input  logic [`RC4_DATA_W-1:0] pwdata,
	output logic [`RC4_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr
);
	import rc4_pkg::*;

	// Key and restart to the scheduler
	rc4_key_u  key;
	logic      start;
	logic      key_ready;

	// Ciphertext link, holding register to XOR stage
	rc4_word_t cipher_word;
	logic      cipher_valid;
	logic      cipher_ready;

	// Keystream link
	rc4_byte_t ks_byte;
	logic      ks_valid;
	logic      ks_ready;

	// Plaintext link back to the bus
	rc4_word_t plain_word;
	logic      plain_valid;
	logic      plain_ready;

	//////////////////////////////////////////////////////////////////////
	// Stages
	//////////////////////////////////////////////////////////////////////

	rc4_apb_regs i_regs (
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.psel         (psel),
		.penable      (penable),
		.pwrite       (pwrite),
		.paddr        (paddr),
		.pwdata       (pwdata),
		.key_ready    (key_ready),
		.cipher_ready (cipher_ready),
		.plain_word   (plain_word),
		.plain_valid  (plain_valid),
		.prdata       (prdata),
		.pready       (pready),
		.pslverr      (pslverr),
		.key          (key),
		.start        (start),
		.cipher_word  (cipher_word),
		.cipher_valid (cipher_valid),
		.plain_ready  (plain_ready)
	);

	rc4_keystream i_keystream (
		.tb_clk    (tb_clk),
		.rst_n     (rst_n),
		.key       (key),
		.start     (start),
		.ks_ready  (ks_ready),
		.key_ready (key_ready),
		.ks_byte   (ks_byte),
		.ks_valid  (ks_valid)
	);

	rc4_word_xor i_word_xor (
		.tb_clk       (tb_clk),
		.rst_n        (rst_n),
		.start        (start),
		.cipher_word  (cipher_word),
		.cipher_valid (cipher_valid),
		.ks_byte      (ks_byte),
		.ks_valid     (ks_valid),
		.plain_ready  (plain_ready),
		.cipher_ready (cipher_ready),
		.ks_ready     (ks_ready),
		.plain_word   (plain_word),
		.plain_valid  (plain_valid)
	);

endmodule

/* hw/rc4_word_xor.sv */
`timescale 1ns/1ps
`include "rc4_cfg.svh"

module rc4_word_xor (
	input  logic               tb_clk,
	input  logic               rst_n,
	input  logic               start,
	input  rc4_pkg::rc4_word_t cipher_word,
	input  logic               cipher_valid,
	input  rc4_pkg::rc4_byte_t ks_byte,
	input  logic               ks_valid,
	input  logic               plain_ready,
	output logic               cipher_ready,
	output logic               ks_ready,
	output rc4_pkg::rc4_word_t plain_word,
	output logic               plain_valid
);
	import rc4_pkg::*;

	// Byte lanes per data word
	localparam int LANES  = `RC4_DATA_W / 8;
	localparam int LANE_W = $clog2(LANES);

	logic              busy;
	logic [LANE_W-1:0] lane;
	logic              cipher_take;
	logic              ks_take;
	rc4_byte_t         lane_byte;

	// Idle only when no word is being worked on or held
	assign cipher_ready = ~busy & ~plain_valid;
	assign ks_ready     = busy;

	assign cipher_take = cipher_valid & cipher_ready;
	assign ks_take     = ks_valid & ks_ready;

	// Current lane, least significant byte first
	assign lane_byte = plain_word[lane*8 +: 8] ^ ks_byte;

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			busy        <= 1'b0;
			lane        <= '0;
			plain_valid <= 1'b0;
		end
		else if (start)
		begin
			// Restart drops the word in progress
			busy        <= 1'b0;
			lane        <= '0;
			plain_valid <= 1'b0;
		end
		else
		begin
			if (cipher_take)
			begin
				busy <= 1'b1;
				lane <= '0;
			end
			if (ks_take)
			begin
				lane <= lane + 1'b1;
				// Fourth byte finishes the word
				if (lane == LANE_W'(LANES - 1))
				begin
					busy        <= 1'b0;
					plain_valid <= 1'b1;
				end
			end
			if (plain_valid && plain_ready)
				plain_valid <= 1'b0;
		end
	end

	// Word register, ciphertext in and plaintext out
	always_ff @(posedge tb_clk)
	begin
		if (cipher_take)
			plain_word <= cipher_word;
		else if (ks_take)
			plain_word[lane*8 +: 8] <= lane_byte;
	end

endmodule

/* hw/rc4_keystream.sv */
`timescale 1ns/1ps
`include "rc4_cfg.svh"

module rc4_keystream (
	input  logic               tb_clk,
	input  logic               rst_n,
	input  rc4_pkg::rc4_key_u  key,
	input  logic               start,
	input  logic               ks_ready,
	output logic               key_ready,
	output rc4_pkg::rc4_byte_t ks_byte,
	output logic               ks_valid
);
	import rc4_pkg::*;

	// Key byte select width
	localparam int KEY_IDX_W = $clog2(`RC4_KEY_BYTES);

	// Last table index, end of fill and of key scheduling
	localparam rc4_byte_t LAST_IDX = rc4_byte_t'(`RC4_TABLE_SIZE - 1);

	//////////////////////////////////////////////////////////////////////
	// FSM encoding
	//////////////////////////////////////////////////////////////////////

	// Waiting for START
	localparam logic [3:0] ST_IDLE   = 4'd0;
	// Identity fill, one entry per cycle
	localparam logic [3:0] ST_INIT   = 4'd1;
	// Key scheduling, read S[i] and step j
	localparam logic [3:0] ST_KSA_RD = 4'd2;
	// Key scheduling, S[i] gets S[j]
	localparam logic [3:0] ST_KSA_WI = 4'd3;
	// Key scheduling, S[j] gets old S[i]
	localparam logic [3:0] ST_KSA_WJ = 4'd4;
	// Generation, step i, read S[i] and step j
	localparam logic [3:0] ST_GEN_RD = 4'd5;
	// Generation, S[i] gets S[j]
	localparam logic [3:0] ST_GEN_WI = 4'd6;
	// Generation, S[j] gets old S[i]
	localparam logic [3:0] ST_GEN_WJ = 4'd7;
	// Keystream byte offered until taken
	localparam logic [3:0] ST_OUT    = 4'd8;

	logic [3:0] state;

	// State table
	rc4_byte_t s_tbl [0:`RC4_TABLE_SIZE-1];

	rc4_byte_t idx_i;
	rc4_byte_t idx_j;
	rc4_byte_t i_nxt;
	rc4_byte_t rd_addr;
	rc4_byte_t s_rd_i;
	rc4_byte_t s_rd_j;
	rc4_byte_t key_byte;
	rc4_byte_t si_q;
	rc4_byte_t sj_q;
	rc4_byte_t ks_idx;

	//////////////////////////////////////////////////////////////////////
	// Table reads
	//////////////////////////////////////////////////////////////////////

	// Generation reads one entry ahead of i
	assign i_nxt   = idx_i + 8'd1;
	assign rd_addr = (state == ST_GEN_RD) ? i_nxt : idx_i;
	assign s_rd_i  = s_tbl[rd_addr];
	assign s_rd_j  = s_tbl[idx_j];

	// Key index is i modulo the key length
	assign key_byte = key.bytes[idx_i[KEY_IDX_W-1:0]];

	// Output index from the swapped pair, 8-bit wrap
	assign ks_idx  = si_q + sj_q;
	// No table writes happen in ST_OUT, so the lookup is stable
	assign ks_byte = s_tbl[ks_idx];
	assign ks_valid = (state == ST_OUT);

	//////////////////////////////////////////////////////////////////////
	// Table writes
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge tb_clk)
	begin
		case (state)
			ST_INIT:
				s_tbl[idx_i] <= idx_i;
			ST_KSA_WI, ST_GEN_WI:
				s_tbl[idx_i] <= s_rd_j;
			ST_KSA_WJ, ST_GEN_WJ:
				s_tbl[idx_j] <= si_q;
			default:
				;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			state     <= ST_IDLE;
			idx_i     <= '0;
			idx_j     <= '0;
			key_ready <= 1'b0;
		end
		else if (start)
		begin
			// START from any state reschedules from scratch
			state     <= ST_INIT;
			idx_i     <= '0;
			idx_j     <= '0;
			key_ready <= 1'b0;
		end
		else
		begin
			case (state)
				ST_INIT:
				begin
					idx_i <= i_nxt;
					// i wraps back to 0 for the swap loop
					if (idx_i == LAST_IDX)
						state <= ST_KSA_RD;
				end
				ST_KSA_RD:
				begin
					idx_j <= idx_j + s_rd_i + key_byte;
					state <= ST_KSA_WI;
				end
				ST_KSA_WI:
					state <= ST_KSA_WJ;
				ST_KSA_WJ:
				begin
					idx_i <= i_nxt;
					if (idx_i == LAST_IDX)
					begin
						// Generation starts with i and j at 0
						idx_j     <= '0;
						key_ready <= 1'b1;
						state     <= ST_GEN_RD;
					end
					else
						state <= ST_KSA_RD;
				end
				ST_GEN_RD:
				begin
					idx_i <= i_nxt;
					idx_j <= idx_j + s_rd_i;
					state <= ST_GEN_WI;
				end
				ST_GEN_WI:
					state <= ST_GEN_WJ;
				ST_GEN_WJ:
					state <= ST_OUT;
				ST_OUT:
				begin
					// Advance only once the byte is taken
					if (ks_ready)
						state <= ST_GEN_RD;
				end
				default:
					state <= ST_IDLE;
			endcase
		end
	end

	// Swap operands
	// si_q holds old S[i] for the second write
	// sj_q holds old S[j] for the output index
	always_ff @(posedge tb_clk)
	begin
		if (state == ST_KSA_RD || state == ST_GEN_RD)
			si_q <= s_rd_i;
		if (state == ST_GEN_WI)
			sj_q <= s_rd_j;
	end

endmodule

/* hw/rc4_apb_regs.sv */
`timescale 1ns/1ps
`include "rc4_cfg.svh"

module rc4_apb_regs (
	input  logic                   tb_clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [`RC4_ADDR_W-1:0] paddr,
	input  logic [`RC4_DATA_W-1:0] pwdata,
	input  logic                   key_ready,
	input  logic                   cipher_ready,
	input  rc4_pkg::rc4_word_t     plain_word,
	input  logic                   plain_valid,
	output logic [`RC4_DATA_W-1:0] prdata,
	output logic                   pready,
	output logic                   pslverr,
	output rc4_pkg::rc4_key_u      key,
	output logic                   start,
	output rc4_pkg::rc4_word_t     cipher_word,
	output logic                   cipher_valid,
	output logic                   plain_ready
);
	import rc4_pkg::*;

	logic      access;
	logic      sel_ctrl;
	logic      sel_key;
	logic      sel_status;
	logic      sel_data;
	logic      unmapped;
	logic      early_data;
	logic      wr_done;
	logic      started;
	logic      hold_full;
	rc4_word_t status_word;

	//////////////////////////////////////////////////////////////////////
	// Address decode
	//////////////////////////////////////////////////////////////////////

	// Access phase of an APB transfer
	assign access = psel & penable;

	assign sel_ctrl   = (paddr == `RC4_REG_CTRL);
	assign sel_key    = (paddr == `RC4_REG_KEY);
	assign sel_status = (paddr == `RC4_REG_STATUS);
	assign sel_data   = (paddr == `RC4_REG_DATA);
	assign unmapped   = ~(sel_ctrl | sel_key | sel_status | sel_data);

	// Ciphertext pushed before the first START since reset
	assign early_data = sel_data & pwrite & ~started;

	// Error responses finish at once
	// DATA write waits for an empty holding register
	// DATA read waits for a finished plaintext word
	always_comb
	begin
		if (!access)
			pready = 1'b0;
		else if (unmapped || early_data)
			pready = 1'b1;
		else if (sel_data)
			pready = pwrite ? ~hold_full : plain_valid;
		else
			pready = 1'b1;
	end

	assign pslverr = access & (unmapped | early_data);

	// Write that completes without error this cycle
	assign wr_done = access & pwrite & pready & ~pslverr;

	// Pops the plaintext word as the DATA read completes
	assign plain_ready = access & ~pwrite & sel_data & plain_valid;

	//////////////////////////////////////////////////////////////////////
	// Read mux
	//////////////////////////////////////////////////////////////////////

	// STATUS bits: key_ready, plain_valid, cipher_busy
	assign status_word = {{(`RC4_DATA_W-3){1'b0}}, hold_full, plain_valid, key_ready};

	always_comb
	begin
		prdata = '0;
		if (sel_key)
			prdata = key.raw;
		else if (sel_status)
			prdata = status_word;
		else if (sel_data)
			prdata = plain_word;
	end

	//////////////////////////////////////////////////////////////////////
	// Control registers and holding register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge tb_clk)
	begin
		if (!rst_n)
		begin
			key       <= '0;
			started   <= 1'b0;
			start     <= 1'b0;
			hold_full <= 1'b0;
		end
		else
		begin
			// START leaves as a one-cycle pulse after the CTRL write
			start <= wr_done & sel_ctrl & pwdata[0];
			if (wr_done && sel_ctrl && pwdata[0])
				started <= 1'b1;
			if (wr_done && sel_key)
				key.raw <= pwdata;
			// Restart drops any queued ciphertext
			if (start)
				hold_full <= 1'b0;
			else if (wr_done && sel_data)
				hold_full <= 1'b1;
			else if (cipher_valid && cipher_ready)
				hold_full <= 1'b0;
		end
	end

	// Ciphertext payload
	always_ff @(posedge tb_clk)
	begin
		if (wr_done && sel_data)
			cipher_word <= pwdata;
	end

	assign cipher_valid = hold_full;

endmodule

/* hw/rc4_pkg.sv */
`include "rc4_cfg.svh"

package rc4_pkg;

	// One byte of the state table, the key or the keystream
	typedef logic [7:0] rc4_byte_t;

	// One bus data word
	typedef logic [`RC4_DATA_W-1:0] rc4_word_t;

	// Key word
	// Written whole over the bus as raw
	// Walked byte by byte by the key scheduler as bytes
	// Byte 0 sits in bits 7:0
	typedef union packed {
		rc4_word_t                      raw;
		rc4_byte_t [`RC4_KEY_BYTES-1:0] bytes;
	} rc4_key_u;

endpackage

/* hw/rc4_cfg.svh */
`ifndef RC4_CFG_SVH
`define RC4_CFG_SVH

//////////////////////////////////////////////////////////////////////
// Bus geometry
//////////////////////////////////////////////////////////////////////

// APB address width, enough for four word registers
`define RC4_ADDR_W 4

// APB data word width
`define RC4_DATA_W 32

//////////////////////////////////////////////////////////////////////
// Register byte offsets
//////////////////////////////////////////////////////////////////////

`define RC4_REG_CTRL   4'h0
`define RC4_REG_KEY    4'h4
`define RC4_REG_STATUS 4'h8
`define RC4_REG_DATA   4'hC

// Cipher state table entries
`define RC4_TABLE_SIZE 256

// Fixed key length in bytes
`define RC4_KEY_BYTES 4

`endif
